//--- src/acc_pkg.sv
`default_nettype none

package acc_pkg;

    // ========================================================================
    // Widths
    // ========================================================================

    localparam int addr_w       = 16;
    localparam int wr_data_w    = 32;
    localparam int rd_data_w    = 512;
    localparam int digest_w     = 256;
    localparam int digest_words = 8;
    localparam int hash_rounds  = 64;
    localparam int pass_count   = 3;

    // ========================================================================
    // Memory map and status codes
    // ========================================================================

    // Host and accelerator communication blocks
    localparam logic [addr_w-1:0] hcb_start_addr  = 16'h1000;
    localparam logic [addr_w-1:0] acb_start_addr  = 16'h5000;
    // Digest word 0 sits two words past the status word
    localparam logic [addr_w-1:0] acb_h0_addr     = acb_start_addr + 16'h0008;

    // Header halves live on either side of the HCB base
    localparam logic [addr_w-1:0] hdr_addr_first  = hcb_start_addr + 16'h0010;
    localparam logic [addr_w-1:0] hdr_addr_second = hcb_start_addr - 16'h0030;

    localparam logic [wr_data_w-1:0] status_busy = 32'd5;
    localparam logic [wr_data_w-1:0] status_done = 32'd2;

    // ========================================================================
    // Bus and control types
    // ========================================================================

    // CPU store bus as snooped by the accelerator
    typedef struct packed {
        logic                 en;
        logic [addr_w-1:0]    addr;
        logic [wr_data_w-1:0] data;
    } mmio_snoop_t;

    // One single-beat transfer request
    typedef struct packed {
        logic                 we;
        logic [addr_w-1:0]    adr;
        logic [wr_data_w-1:0] dat;
    } mem_cmd_t;

    // Master to slave half of the Wishbone bus
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [addr_w-1:0]    adr;
        logic [wr_data_w-1:0] dat;
    } wb_req_t;

    // Slave to master half, read data is one header half
    typedef struct packed {
        logic                 ack;
        logic [rd_data_w-1:0] dat;
    } wb_rsp_t;

    // Scheduler and compressor strobes
    typedef struct packed {
        logic ms_init;
        logic ms_enable;
        logic cm_is_hashing;
        logic cm_update_a_h;
        logic cm_update_h0_7;
        logic cm_rst_hash_n;     // Active low
        logic should_save_hash;
    } hash_ctrl_t;

    typedef logic [6:0] round_cnt_t;
    typedef logic [1:0] stage_t;

endpackage

`default_nettype wire

//--- src/acc_wb_master.sv
`default_nettype none

module acc_wb_master (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_valid,
    input  acc_pkg::mem_cmd_t cmd,
    output logic             cmd_done,
    output acc_pkg::wb_req_t wb_req,
    input  acc_pkg::wb_rsp_t wb_rsp
);

    import acc_pkg::*;

    // Transfer in flight, drives both cyc and stb
    logic     cyc_q;
    // Captured command, held stable for the whole cycle
    mem_cmd_t cmd_q;

    // ========================================================================
    // Bus cycle control
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc_q <= 1'b0;
        end else if (cyc_q) begin
            // Slave ends the cycle, drop cyc on the next edge
            if (wb_rsp.ack) begin
                cyc_q <= 1'b0;
            end
        end else if (cmd_valid) begin
            cyc_q <= 1'b1;
        end
    end

    // Payload only loads while idle so adr/we/dat cannot move mid-cycle
    always_ff @(posedge clk) begin
        if (!cyc_q && cmd_valid) begin
            cmd_q <= cmd;
        end
    end

    // Completion is the ack itself, read data is valid in this cycle
    assign cmd_done = cyc_q & wb_rsp.ack;

    // Classic single transfer, stb follows cyc
    always_comb begin
        wb_req.cyc = cyc_q;
        wb_req.stb = cyc_q;
        wb_req.we  = cmd_q.we;
        wb_req.adr = cmd_q.adr;
        wb_req.dat = cmd_q.dat;
    end

endmodule

`default_nettype wire

//--- src/acc_hash_pass.sv
`default_nettype none

module acc_hash_pass (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pass_start,
    input  logic                chain,
    output logic                pass_done,
    output acc_pkg::hash_ctrl_t hash_ctrl,
    output acc_pkg::round_cnt_t cm_cycle_count
);

    import acc_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_reset,      // Clear working hash
        st_load,       // [A:H] <- [H0:H7], scheduler init
        st_rounds,     // 64 compression rounds
        st_settle,     // Count at 64, cleared here
        st_fold,       // [H0:H7] <- [H0:H7] + [A:H]
        st_save        // Intermediate hash saved, pass complete
    } pass_state_t;

    pass_state_t state_q;
    round_cnt_t  round_q;

    // ========================================================================
    // Pass sequencer
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    // Chained pass keeps the running hash
                    if (pass_start) begin
                        state_q <= chain ? st_load : st_reset;
                    end
                end
                st_reset:  state_q <= st_load;
                st_load:   state_q <= st_rounds;
                st_rounds: begin
                    if (round_q == round_cnt_t'(hash_rounds - 1)) begin
                        state_q <= st_settle;
                    end
                end
                st_settle: state_q <= st_fold;
                st_fold:   state_q <= st_save;
                st_save:   state_q <= st_idle;
                default:   state_q <= st_idle;
            endcase
        end
    end

    // Round counter, visible to the compressor as the K/W index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            round_q <= '0;
        end else if (state_q == st_rounds) begin
            round_q <= round_q + 1'b1;
        end else if (state_q == st_settle) begin
            round_q <= '0;
        end
    end

    assign cm_cycle_count = round_q;
    assign pass_done      = (state_q == st_save);

    // Strobes decoded straight from state
    always_comb begin
        hash_ctrl.ms_init          = (state_q == st_load);
        hash_ctrl.cm_update_a_h    = (state_q == st_load);
        hash_ctrl.ms_enable        = (state_q == st_rounds);
        hash_ctrl.cm_is_hashing    = (state_q == st_rounds);
        hash_ctrl.cm_update_h0_7   = (state_q == st_fold);
        hash_ctrl.cm_rst_hash_n    = (state_q != st_reset);
        hash_ctrl.should_save_hash = (state_q == st_save);
    end

endmodule

`default_nettype wire

//--- src/acc_job_ctrl.sv
`default_nettype none

module acc_job_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  acc_pkg::mmio_snoop_t           snoop,
    input  logic [acc_pkg::digest_w-1:0]   cm_out,
    output logic                           cmd_valid,
    output acc_pkg::mem_cmd_t              cmd,
    input  logic                           cmd_done,
    output logic                           pass_start,
    output logic                           chain,
    input  logic                           pass_done,
    output acc_pkg::stage_t                msg_sel,
    output logic                           do_buf_hdr
);

    import acc_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_hdr1,       // First header half
        st_busy,       // Busy status write
        st_pass,       // One compression pass
        st_hdr2,       // Second header half, between pass 1 and 2
        st_digest,     // Digest write-back loop
        st_done        // Done status write
    } job_state_t;

    job_state_t                      state_q;
    // High in the first cycle of every state, launches its transfer or pass
    logic                            kick_q;
    stage_t                          stage_q;
    logic [$clog2(digest_words)-1:0] word_q;
    logic                            start;
    logic                            last_stage;
    logic                            last_word;

    // Only a valid-bit store to the status word counts, and only when idle
    assign start = (state_q == st_idle) && snoop.en
                   && (snoop.addr == acb_start_addr) && snoop.data[0];

    assign last_stage = (stage_q == stage_t'(pass_count - 1));
    assign last_word  = (word_q == ($bits(word_q))'(digest_words - 1));

    // ========================================================================
    // Job sequencer
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            kick_q  <= 1'b0;
            stage_q <= '0;
            word_q  <= '0;
        end else begin
            kick_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (start) begin
                        state_q <= st_hdr1;
                        kick_q  <= 1'b1;
                    end
                end
                st_hdr1: begin
                    if (cmd_done) begin
                        state_q <= st_busy;
                        kick_q  <= 1'b1;
                    end
                end
                st_busy: begin
                    if (cmd_done) begin
                        state_q <= st_pass;
                        kick_q  <= 1'b1;
                    end
                end
                st_pass: begin
                    if (pass_done) begin
                        kick_q <= 1'b1;
                        if (last_stage) begin
                            state_q <= st_digest;
                        end else begin
                            // Second header half is needed before pass 2 only
                            state_q <= (stage_q == '0) ? st_hdr2 : st_pass;
                            stage_q <= stage_q + 1'b1;
                        end
                    end
                end
                st_hdr2: begin
                    if (cmd_done) begin
                        state_q <= st_pass;
                        kick_q  <= 1'b1;
                    end
                end
                st_digest: begin
                    // One write per digest word, low word first
                    if (cmd_done) begin
                        kick_q <= 1'b1;
                        word_q <= word_q + 1'b1;
                        if (last_word) begin
                            state_q <= st_done;
                        end
                    end
                end
                st_done: begin
                    if (cmd_done) begin
                        state_q <= st_idle;
                        stage_q <= '0;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // ========================================================================
    // Command and pass outputs
    // ========================================================================

    assign cmd_valid  = kick_q && (state_q != st_pass) && (state_q != st_idle);
    assign pass_start = kick_q && (state_q == st_pass);
    // Pass 2 continues from the hash of pass 1
    assign chain      = (stage_q == stage_t'(1));
    assign msg_sel    = stage_q;
    // Header buffer captures read data in the ack cycle
    assign do_buf_hdr = cmd_done && ((state_q == st_hdr1) || (state_q == st_hdr2));

    always_comb begin
        cmd.we  = 1'b0;
        cmd.adr = '0;
        cmd.dat = '0;
        case (state_q)
            st_hdr1: cmd.adr = hdr_addr_first;
            st_hdr2: cmd.adr = hdr_addr_second;
            st_busy: begin
                cmd.we  = 1'b1;
                cmd.adr = acb_start_addr;
                cmd.dat = status_busy;
            end
            st_digest: begin
                cmd.we  = 1'b1;
                cmd.adr = acb_h0_addr + addr_w'(word_q) * addr_w'(wr_data_w / 8);
                cmd.dat = cm_out[wr_data_w * word_q +: wr_data_w];
            end
            st_done: begin
                cmd.we  = 1'b1;
                cmd.adr = acb_start_addr;
                cmd.dat = status_done;
            end
            default: cmd.we = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/acc_control_unit.sv
`default_nettype none

module acc_control_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  acc_pkg::mmio_snoop_t         snoop,
    output acc_pkg::wb_req_t             wb_req,
    input  acc_pkg::wb_rsp_t             wb_rsp,
    input  logic [acc_pkg::digest_w-1:0] cm_out,
    output acc_pkg::hash_ctrl_t          hash_ctrl,
    output acc_pkg::round_cnt_t          cm_cycle_count,
    output acc_pkg::stage_t              msg_sel,
    output logic                         do_buf_hdr
);

    import acc_pkg::*;

    // Job sequencer to bus master
    logic     cmd_valid;
    mem_cmd_t cmd;
    logic     cmd_done;
    // Job sequencer to pass sequencer
    logic     pass_start;
    logic     chain;
    logic     pass_done;

    acc_job_ctrl u_job_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .snoop      (snoop),
        .cm_out     (cm_out),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_done   (cmd_done),
        .pass_start (pass_start),
        .chain      (chain),
        .pass_done  (pass_done),
        .msg_sel    (msg_sel),
        .do_buf_hdr (do_buf_hdr)
    );

    acc_wb_master u_wb_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    acc_hash_pass u_hash_pass (
        .clk            (clk),
        .rst_n          (rst_n),
        .pass_start     (pass_start),
        .chain          (chain),
        .pass_done      (pass_done),
        .hash_ctrl      (hash_ctrl),
        .cm_cycle_count (cm_cycle_count)
    );

endmodule

`default_nettype wire

//--- verif/acc_mem_model.sv
`default_nettype none

module acc_mem_model (
    input  logic                         clk,
    input  logic                         rst_n,
    input  acc_pkg::wb_req_t             wb_req,
    input  logic [acc_pkg::digest_w-1:0] cm_out,
    output acc_pkg::wb_rsp_t             wb_rsp,
    output int                           xfer_count,
    output logic                         error
);

    timeunit 1ns;
    timeprecision 1ns;

    import acc_pkg::*;

    // Ack delay source advanced once per transfer
    logic [31:0]          rng_q   = 32'd1796;
    logic [1:0]           wait_q  = 2'd0;
    logic                 ack_q   = 1'b0;
    logic [rd_data_w-1:0] rdat_q  = '0;
    int                   count_q = 0;
    logic                 error_q = 1'b0;
    mem_cmd_t             exp_cmd;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected transfer k within one job of twelve
    // Header read, busy write, header read, eight digest words, done write
    function automatic mem_cmd_t expected_xfer(input int k, input logic [255:0] digest);
        mem_cmd_t e;
        e.we  = 1'b1;
        e.adr = 16'h5000;
        e.dat = 32'd0;
        if (k == 0) begin
            e.we  = 1'b0;
            e.adr = 16'h1010;
        end else if (k == 1) begin
            e.dat = 32'd5;
        end else if (k == 2) begin
            e.we  = 1'b0;
            e.adr = 16'h0FD0;
        end else if (k < 11) begin
            // Digest word i at status word plus 8 plus 4i
            e.adr = 16'h5008 + 16'(4 * (k - 3));
            e.dat = digest[32 * (k - 3) +: 32];
        end else begin
            e.dat = 32'd2;
        end
        return e;
    endfunction

    assign exp_cmd = expected_xfer(count_q % 12, cm_out);

    // ========================================================================
    // Slave response and transfer check
    // ========================================================================

    always @(posedge clk) begin
        if (!rst_n) begin
            ack_q  <= 1'b0;
            wait_q <= 2'd0;
        end else if (ack_q) begin
            // Master samples ack on this edge and the transfer completes here
            assert (wb_req.cyc && wb_req.we == exp_cmd.we && wb_req.adr == exp_cmd.adr
                    && (!exp_cmd.we || wb_req.dat == exp_cmd.dat))
            else begin
                $display("MISMATCH time=%0t signal=wb_req got=%0b/%h/%h expected=%0b/%h/%h",
                         $time, wb_req.we, wb_req.adr, wb_req.dat,
                         exp_cmd.we, exp_cmd.adr, exp_cmd.dat);
                error_q <= 1'b1;
            end
            ack_q   <= 1'b0;
            count_q <= count_q + 1;
            rng_q   <= xorshift(rng_q);
        end else if (wb_req.cyc && wb_req.stb) begin
            // Extra wait of 0 to 3 cycles before ack
            if (wait_q == rng_q[1:0]) begin
                ack_q  <= 1'b1;
                wait_q <= 2'd0;
                rdat_q <= {16{wb_req.adr, 16'hC3A5}};
            end else begin
                wait_q <= wait_q + 2'd1;
            end
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;
    assign xfer_count = count_q;
    assign error      = error_q;

endmodule

`default_nettype wire

//--- verif/tb_acc_control.sv
`default_nettype none

module tb_acc_control;

    timeunit 1ns;
    timeprecision 1ns;

    import acc_pkg::*;

    localparam logic [255:0] cm_value =
        256'h3f8c21d7_9ae40b65_c17d5e32_84b6f90a_5d23c8e1_0f7a49b6_e28d13c5_76b0fa4d;

    logic            clk;
    logic            rst_n;
    mmio_snoop_t     snoop;
    wb_req_t         wb_req;
    wb_rsp_t         wb_rsp;
    logic [255:0]    cm_out;
    hash_ctrl_t      hash_ctrl;
    round_cnt_t      cm_cycle_count;
    stage_t          msg_sel;
    logic            do_buf_hdr;
    int              xfer_count;
    logic            model_error;

    // Previous cycle, for stability and ordering checks
    wb_req_t         prev_req;
    logic            prev_ack;
    hash_ctrl_t      prev_ctrl;
    // Event counters over the whole run
    int              run_len = 0;
    int              runs    = 0;
    int              folds   = 0;
    int              saves   = 0;
    int              resets  = 0;
    int              strobes = 0;

    acc_control_unit DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .snoop          (snoop),
        .wb_req         (wb_req),
        .wb_rsp         (wb_rsp),
        .cm_out         (cm_out),
        .hash_ctrl      (hash_ctrl),
        .cm_cycle_count (cm_cycle_count),
        .msg_sel        (msg_sel),
        .do_buf_hdr     (do_buf_hdr)
    );

    acc_mem_model u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .cm_out     (cm_out),
        .wb_rsp     (wb_rsp),
        .xfer_count (xfer_count),
        .error      (model_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================================================
    // Failure reporting and helpers
    // ========================================================================

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR time=%0t %s", $time, msg);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("MISMATCH time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
        abort_run();
    endtask

    // One CPU store, held for a single cycle
    task automatic store_word(input logic [15:0] addr, input logic [31:0] data);
        @(posedge clk);
        snoop <= '{1'b1, addr, data};
        @(posedge clk);
        snoop.en <= 1'b0;
    endtask

    task automatic wait_transfers(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (xfer_count < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) report_error("timeout waiting for bus transfers");
        end
    endtask

    task automatic wait_enable(input int limit);
        int cycles;
        cycles = 0;
        while (!hash_ctrl.ms_enable) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) report_error("timeout waiting for a compression run");
        end
    endtask

    // Bus must stay quiet for n cycles
    task automatic idle_window(input int n);
        int base;
        base = xfer_count;
        repeat (n) begin
            @(posedge clk);
            assert (!wb_req.cyc && xfer_count == base)
            else report_error("bus transfer started without a valid start store");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    task automatic check_totals(input int jobs);
        check_count("ms_enable runs", runs, 3 * jobs);
        check_count("cm_update_h0_7 pulses", folds, 3 * jobs);
        check_count("should_save_hash pulses", saves, 3 * jobs);
        check_count("cm_rst_hash_n pulses", resets, 2 * jobs);
        check_count("do_buf_hdr pulses", strobes, 2 * jobs);
    endtask

    // ========================================================================
    // Cycle checks on bus and control outputs
    // ========================================================================

    always @(posedge clk) begin
        assert (!model_error) else report_error("memory model saw a wrong transfer");
        if (rst_n) begin
            assert (wb_req.stb == wb_req.cyc)
            else report_mismatch("wb_req.stb", wb_req.stb, wb_req.cyc);
            // Request held until ack
            if (prev_req.cyc && !prev_ack && wb_req.cyc) begin
                assert (wb_req.adr == prev_req.adr)
                else report_mismatch("wb_req.adr", wb_req.adr, prev_req.adr);
                assert (wb_req.we == prev_req.we)
                else report_mismatch("wb_req.we", wb_req.we, prev_req.we);
                assert (wb_req.dat == prev_req.dat)
                else report_mismatch("wb_req.dat", wb_req.dat, prev_req.dat);
            end
            // Header strobe only in read ack cycles
            assert (do_buf_hdr == (wb_rsp.ack && wb_req.cyc && !wb_req.we))
            else report_mismatch("do_buf_hdr", do_buf_hdr, !do_buf_hdr);
            assert (hash_ctrl.cm_is_hashing == hash_ctrl.ms_enable)
            else report_mismatch("cm_is_hashing", hash_ctrl.cm_is_hashing,
                                 hash_ctrl.ms_enable);
            if (hash_ctrl.ms_enable) begin
                assert (int'(cm_cycle_count) == run_len)
                else report_mismatch("cm_cycle_count", cm_cycle_count, run_len);
                assert (int'(msg_sel) == runs % 3)
                else report_mismatch("msg_sel", msg_sel, runs % 3);
                if (!prev_ctrl.ms_enable) begin
                    assert (prev_ctrl.ms_init && prev_ctrl.cm_update_a_h)
                    else report_error("run not preceded by ms_init with cm_update_a_h");
                end
                run_len <= run_len + 1;
            end else begin
                if (prev_ctrl.ms_enable) begin
                    assert (run_len == 64) else report_mismatch("ms_enable length", run_len, 64);
                    runs <= runs + 1;
                end
                run_len <= 0;
            end
            // Hash reset only ahead of runs 1 and 3, then a load
            if (!hash_ctrl.cm_rst_hash_n) begin
                assert (runs % 3 != 1) else report_error("hash reset before the chained run");
                resets <= resets + 1;
            end
            if (!prev_ctrl.cm_rst_hash_n) begin
                assert (hash_ctrl.cm_update_a_h)
                else report_mismatch("cm_update_a_h", hash_ctrl.cm_update_a_h, 1);
            end
            if (hash_ctrl.cm_update_h0_7) folds <= folds + 1;
            if (hash_ctrl.should_save_hash) saves <= saves + 1;
            if (do_buf_hdr) strobes <= strobes + 1;
        end
        prev_req  <= wb_req;
        prev_ack  <= wb_rsp.ack;
        prev_ctrl <= hash_ctrl;
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        rst_n  = 1'b0;
        snoop  = '0;
        cm_out = cm_value;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // Idle outputs straight out of reset
        assert (!wb_req.cyc) else report_mismatch("wb_req.cyc", wb_req.cyc, 0);
        assert (hash_ctrl == 7'b000_0010)
        else report_mismatch("hash_ctrl", hash_ctrl, 7'b000_0010);
        assert (!do_buf_hdr) else report_mismatch("do_buf_hdr", do_buf_hdr, 0);
        assert (msg_sel == 2'd0) else report_mismatch("msg_sel", msg_sel, 0);
        assert (cm_cycle_count == 7'd0)
        else report_mismatch("cm_cycle_count", cm_cycle_count, 0);

        // Wrong address, then valid bit clear
        store_word(16'h5004, 32'h0000_0001);
        store_word(16'h5000, 32'h0000_0004);
        idle_window(20);

        // First job, with a second start store while it runs
        store_word(16'h5000, 32'h0000_0001);
        wait_enable(200);
        store_word(16'h5000, 32'h0000_0001);
        wait_transfers(12, 2000);
        idle_window(20);
        check_totals(1);

        // Second job, other status bits set along with valid
        store_word(16'h5000, 32'h0000_0003);
        wait_transfers(24, 2000);
        idle_window(10);
        check_totals(2);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
src/acc_pkg.sv
src/acc_wb_master.sv
src/acc_hash_pass.sv
src/acc_job_ctrl.sv
src/acc_control_unit.sv
verif/acc_mem_model.sv
verif/tb_acc_control.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_acc_control -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_acc_control
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
